// File: verilog/pid_lock_defines.svh
`ifndef PID_LOCK_DEFINES_SVH
`define PID_LOCK_DEFINES_SVH

////////////////////////////////////////////////////////////
// datapath widths
////////////////////////////////////////////////////////////

`define W_SAMPLE	16	// adc sample word
`define W_SUM		48	// pid sum, wide enough for the integrator
`define W_OUT		16	// dac word
`define W_MLT		10	// output multiplier
`define W_DIV		16	// output divisor
`define W_COEF		16	// kp, ki, kd

// cycles spent in OPP_COMPUTE
`define COMP_LATENCY	1

////////////////////////////////////////////////////////////
// output stage reset values
////////////////////////////////////////////////////////////

`define MAX_INIT	16'h3fff	// upper bound
`define MIN_INIT	16'hc001	// lower bound
`define OUT_INIT	16'h0000	// start value and unlocked output
`define MLT_INIT	10'd1		// unity gain
`define DVS_INIT	16'd1		// never zero

`endif

// File: verilog/lock_data_pkg.sv
`include "pid_lock_defines.svh"

// datapath word types and the two datapath FSMs
package lock_data_pkg;

	typedef logic signed [`W_SAMPLE-1:0]	sample_t;	// input sample, also setpoint
	typedef logic signed [`W_SUM-1:0]		sum_t;		// p + i + d
	typedef logic signed [`W_OUT-1:0]		out_t;		// dac word

	// pid filter sequence
	typedef enum logic [1:0] {
		FILT_IDLE	= 2'd0,	// wait for a sample
		FILT_TERMS	= 2'd1,	// register p, i and d terms
		FILT_SUM	= 2'd2,	// add the terms
		FILT_SEND	= 2'd3	// sum_valid strobe
	} filter_state_e;

	// output preprocessor sequence
	typedef enum logic [1:0] {
		OPP_IDLE		= 2'd0,	// wait for a pid sum
		OPP_COMPUTE		= 2'd1,	// scale, accumulate, clamp
		OPP_SEND		= 2'd2,	// data_valid strobe
		OPP_WRITEBACK	= 2'd3	// keep result as previous output
	} opp_state_e;

endpackage

// File: verilog/lock_config_pkg.sv
`include "pid_lock_defines.svh"

// front panel setting types

package lock_config_pkg;

	////////////////////////////////////////////////////////////
	// filter settings
	////////////////////////////////////////////////////////////

	typedef logic signed [`W_COEF-1:0]	coef_t;	// kp, ki, kd

	////////////////////////////////////////////////////////////
	// output stage settings
	////////////////////////////////////////////////////////////

	typedef logic signed [`W_MLT-1:0]	mult_t;	// gain numerator
	typedef logic signed [`W_DIV-1:0]	div_t;	// gain denominator, nonzero

	// bounds and init value of the output stage use lock_data_pkg::out_t
	// since they share the dac word format

endpackage

// File: verilog/lock_ifs.sv
`timescale 1ns/1ps

////////////////////////////////////////////////////////////
// filter coefficients, bank to pid filter
////////////////////////////////////////////////////////////

interface pid_coef_if;
	lock_data_pkg::sample_t		setpoint;	// lock target
	lock_config_pkg::coef_t		kp;			// proportional gain
	lock_config_pkg::coef_t		ki;			// integral gain
	lock_config_pkg::coef_t		kd;			// derivative gain

	modport bank	(output setpoint, kp, ki, kd);
	modport filter	(input setpoint, kp, ki, kd);
endinterface

////////////////////////////////////////////////////////////
// output stage settings, bank to preprocessor
////////////////////////////////////////////////////////////

interface opp_cfg_if;
	lock_data_pkg::out_t		output_max;		// upper clamp
	lock_data_pkg::out_t		output_min;		// lower clamp
	lock_data_pkg::out_t		output_init;	// unlocked value and reload value
	lock_config_pkg::mult_t		multiplier;		// scale numerator
	lock_config_pkg::div_t		divisor;		// scale denominator
	logic						load;			// one cycle after an accepted update

	modport bank	(output output_max, output_min, output_init, multiplier, divisor, load);
	modport opp		(input output_max, output_min, output_init, multiplier, divisor, load);
endinterface

// File: verilog/lock_config_bank.sv
`timescale 1ns/1ps
`include "pid_lock_defines.svh"

module lock_config_bank (
	input	logic						clk_in,
	input	logic						reset_in,
	input	logic						update_en_in,	// arms the update strobe
	input	logic						update_in,		// load all settings
	input	lock_data_pkg::sample_t		setpoint_in,
	input	lock_config_pkg::coef_t		kp_in,
	input	lock_config_pkg::coef_t		ki_in,
	input	lock_config_pkg::coef_t		kd_in,
	input	lock_data_pkg::out_t		output_max_in,
	input	lock_data_pkg::out_t		output_min_in,
	input	lock_data_pkg::out_t		output_init_in,
	input	lock_config_pkg::mult_t		multiplier_in,
	input	lock_config_pkg::div_t		divisor_in,
	pid_coef_if.bank					coef,			// to pid filter
	opp_cfg_if.bank						opp_cfg			// to output preprocessor
);

	logic	do_update;	// guarded update strobe

	assign do_update = update_in & update_en_in;

	////////////////////////////////////////////////////////////
	// settings registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			coef.setpoint			<= '0;
			coef.kp					<= '0;			// filter silent until configured
			coef.ki					<= '0;
			coef.kd					<= '0;
			opp_cfg.output_max		<= `MAX_INIT;
			opp_cfg.output_min		<= `MIN_INIT;
			opp_cfg.output_init		<= `OUT_INIT;
			opp_cfg.multiplier		<= `MLT_INIT;
			opp_cfg.divisor			<= `DVS_INIT;
		end else if (do_update) begin
			coef.setpoint			<= setpoint_in;
			coef.kp					<= kp_in;
			coef.ki					<= ki_in;
			coef.kd					<= kd_in;
			opp_cfg.output_max		<= output_max_in;
			opp_cfg.output_min		<= output_min_in;
			opp_cfg.output_init		<= output_init_in;
			opp_cfg.multiplier		<= multiplier_in;
			// zero divisor would stall nothing but give garbage, store one
			opp_cfg.divisor			<= (divisor_in != '0) ? divisor_in : `W_DIV'(1);
		end
	end

	// reload strobe for the previous output, one cycle after the load
	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			opp_cfg.load <= 1'b0;
		end else begin
			opp_cfg.load <= do_update;	// settings already valid then
		end
	end

endmodule

// File: verilog/pid_filter.sv
`timescale 1ns/1ps
`include "pid_lock_defines.svh"

module pid_filter (
	input	logic						clk_in,
	input	logic						reset_in,
	input	lock_data_pkg::sample_t		sample_in,			// adc sample
	input	logic						sample_valid_in,	// single cycle strobe
	input	logic						lock_en,			// low clears i and d history
	pid_coef_if.filter					coef,
	output	lock_data_pkg::sum_t		sum,				// p + i + d
	output	logic						sum_valid			// high in FILT_SEND only
);

	localparam int W_ERR	= `W_SAMPLE + 1;	// setpoint minus sample
	localparam int W_DIFF	= `W_SAMPLE + 2;	// error minus previous error

	lock_data_pkg::filter_state_e	state;
	lock_data_pkg::filter_state_e	state_next;

	lock_data_pkg::sample_t			sample_q;	// captured in idle
	logic signed [W_ERR-1:0]		error;
	logic signed [W_ERR-1:0]		error_prev;	// for the derivative
	logic signed [W_DIFF-1:0]		error_diff;
	lock_data_pkg::sum_t			p_term;
	lock_data_pkg::sum_t			i_term;		// running integral
	lock_data_pkg::sum_t			d_term;

	////////////////////////////////////////////////////////////
	// error path
	////////////////////////////////////////////////////////////

	assign error		= W_ERR'(coef.setpoint) - W_ERR'(sample_q);
	assign error_diff	= W_DIFF'(error) - W_DIFF'(error_prev);
	assign sum_valid	= (state == lock_data_pkg::FILT_SEND);

	// sample capture, strobes outside idle are dropped
	always_ff @(posedge clk_in) begin
		if ((state == lock_data_pkg::FILT_IDLE) && sample_valid_in) begin
			sample_q <= sample_in;
		end
	end

	// p and d terms, no history of their own
	always_ff @(posedge clk_in) begin
		if (state == lock_data_pkg::FILT_TERMS) begin
			p_term <= lock_data_pkg::sum_t'(coef.kp) * lock_data_pkg::sum_t'(error);
			d_term <= lock_data_pkg::sum_t'(coef.kd) * lock_data_pkg::sum_t'(error_diff);
		end
	end

	// integrator and previous error, held at zero while unlocked
	always_ff @(posedge clk_in) begin
		if (reset_in || !lock_en) begin
			i_term		<= '0;
			error_prev	<= '0;
		end else if (state == lock_data_pkg::FILT_TERMS) begin
			i_term		<= i_term + lock_data_pkg::sum_t'(coef.ki) *
				lock_data_pkg::sum_t'(error);	// wraps at W_SUM
			error_prev	<= error;
		end
	end

	// final adder
	always_ff @(posedge clk_in) begin
		if (state == lock_data_pkg::FILT_SUM) begin
			sum <= p_term + i_term + d_term;
		end
	end

	////////////////////////////////////////////////////////////
	// FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			state <= lock_data_pkg::FILT_IDLE;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = state;	// hold by default
		case (state)
			lock_data_pkg::FILT_IDLE: begin
				if (sample_valid_in) begin
					state_next = lock_data_pkg::FILT_TERMS;
				end
			end
			lock_data_pkg::FILT_TERMS:	state_next = lock_data_pkg::FILT_SUM;
			lock_data_pkg::FILT_SUM:	state_next = lock_data_pkg::FILT_SEND;
			lock_data_pkg::FILT_SEND:	state_next = lock_data_pkg::FILT_IDLE;	// one cycle
			default:					state_next = lock_data_pkg::FILT_IDLE;
		endcase
	end

endmodule

// File: verilog/output_preprocessor.sv
`timescale 1ns/1ps
`include "pid_lock_defines.svh"

module output_preprocessor (
	input	logic						clk_in,
	input	logic						reset_in,
	input	lock_data_pkg::sum_t		sum_in,			// from pid filter
	input	logic						sum_valid_in,	// single cycle strobe
	input	logic						lock_en,		// low selects output_init
	opp_cfg_if.opp						cfg,
	output	lock_data_pkg::out_t		data,			// dac word
	output	logic						data_valid		// high in OPP_SEND only
);

	localparam int W_PROD	= `W_SUM + `W_MLT;	// sum times multiplier
	localparam int W_ACC	= W_PROD + 1;		// room for the previous output
	localparam int W_CNT	= $clog2(`COMP_LATENCY + 1);

	lock_data_pkg::opp_state_e	state;
	lock_data_pkg::opp_state_e	state_next;
	logic [W_CNT-1:0]			comp_cnt;		// cycles spent in compute

	lock_data_pkg::sum_t		sum_q;			// captured pid sum
	lock_data_pkg::out_t		data_prev;		// last sent word

	logic signed [W_PROD-1:0]	scaled;
	logic signed [W_ACC-1:0]	quot;
	logic signed [W_ACC-1:0]	accum;
	logic signed [W_ACC-1:0]	selected;
	logic signed [W_ACC-1:0]	clamp_hi;
	logic signed [W_ACC-1:0]	clamp_lo;

	////////////////////////////////////////////////////////////
	// output datapath
	////////////////////////////////////////////////////////////

	assign scaled	= W_PROD'(sum_q) * W_PROD'(cfg.multiplier);
	assign quot		= W_ACC'(scaled) / W_ACC'(cfg.divisor);			// truncates toward zero
	assign accum	= quot + W_ACC'(data_prev);						// incremental output
	assign selected	= lock_en ? accum : W_ACC'(cfg.output_init);	// unlocked is constant

	// upper bound first so the lower bound wins if they cross
	assign clamp_hi	= (selected > W_ACC'(cfg.output_max)) ? W_ACC'(cfg.output_max) : selected;
	assign clamp_lo	= (clamp_hi < W_ACC'(cfg.output_min)) ? W_ACC'(cfg.output_min) : clamp_hi;

	assign data			= `W_OUT'(clamp_lo);	// in range after clamp
	assign data_valid	= (state == lock_data_pkg::OPP_SEND);

	// sum capture in idle only
	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			sum_q <= '0;
		end else if ((state == lock_data_pkg::OPP_IDLE) && sum_valid_in) begin
			sum_q <= sum_in;
		end
	end

	// reload from output_init wins over writeback
	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			data_prev <= `OUT_INIT;
		end else if (cfg.load) begin
			data_prev <= cfg.output_init;
		end else if (state == lock_data_pkg::OPP_WRITEBACK) begin
			data_prev <= data;
		end
	end

	////////////////////////////////////////////////////////////
	// FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			state		<= lock_data_pkg::OPP_IDLE;
			comp_cnt	<= '0;
		end else begin
			state		<= state_next;
			if (state == lock_data_pkg::OPP_COMPUTE && state_next == state) begin
				comp_cnt <= comp_cnt + 1'b1;
			end else begin
				comp_cnt <= '0;	// restart on every transition
			end
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			lock_data_pkg::OPP_IDLE: begin
				if (sum_valid_in) begin
					state_next = lock_data_pkg::OPP_COMPUTE;
				end
			end
			lock_data_pkg::OPP_COMPUTE: begin
				if (comp_cnt == W_CNT'(`COMP_LATENCY - 1)) begin
					state_next = lock_data_pkg::OPP_SEND;
				end
			end
			lock_data_pkg::OPP_SEND:		state_next = lock_data_pkg::OPP_WRITEBACK;
			lock_data_pkg::OPP_WRITEBACK:	state_next = lock_data_pkg::OPP_IDLE;
			default:						state_next = lock_data_pkg::OPP_IDLE;
		endcase
	end

endmodule

// File: verilog/pid_lock_top.sv
`timescale 1ns/1ps

module pid_lock_top (
	input	logic						clk_in,
	input	logic						reset_in,
	input	logic						sample_valid_in,	// adc strobe
	input	logic						lock_en_in,
	input	logic						update_en_in,
	input	logic						update_in,
	input	lock_data_pkg::sample_t		sample_in,
	input	lock_data_pkg::sample_t		setpoint_in,
	input	lock_config_pkg::coef_t		kp_in,
	input	lock_config_pkg::coef_t		ki_in,
	input	lock_config_pkg::coef_t		kd_in,
	input	lock_data_pkg::out_t		output_max_in,
	input	lock_data_pkg::out_t		output_min_in,
	input	lock_data_pkg::out_t		output_init_in,
	input	lock_config_pkg::mult_t		multiplier_in,
	input	lock_config_pkg::div_t		divisor_in,
	output	lock_data_pkg::out_t		data_out,			// to dac
	output	logic						data_valid_out		// 5 cycles after the sample
);

	////////////////////////////////////////////////////////////
	// internal buses
	////////////////////////////////////////////////////////////

	pid_coef_if				coef_bus ();
	opp_cfg_if				opp_cfg_bus ();

	lock_data_pkg::sum_t	pid_sum;		// filter to preprocessor
	logic					pid_sum_valid;

	lock_config_bank bank_i (
		.clk_in			(clk_in),
		.reset_in		(reset_in),
		.update_en_in	(update_en_in),
		.update_in		(update_in),
		.setpoint_in	(setpoint_in),
		.kp_in			(kp_in),
		.ki_in			(ki_in),
		.kd_in			(kd_in),
		.output_max_in	(output_max_in),
		.output_min_in	(output_min_in),
		.output_init_in	(output_init_in),
		.multiplier_in	(multiplier_in),
		.divisor_in		(divisor_in),
		.coef			(coef_bus.bank),
		.opp_cfg		(opp_cfg_bus.bank)
	);

	pid_filter filter_i (
		.clk_in				(clk_in),
		.reset_in			(reset_in),
		.sample_in			(sample_in),
		.sample_valid_in	(sample_valid_in),
		.lock_en			(lock_en_in),
		.coef				(coef_bus.filter),
		.sum				(pid_sum),
		.sum_valid			(pid_sum_valid)
	);

	output_preprocessor opp_i (
		.clk_in			(clk_in),
		.reset_in		(reset_in),
		.sum_in			(pid_sum),
		.sum_valid_in	(pid_sum_valid),
		.lock_en		(lock_en_in),
		.cfg			(opp_cfg_bus.opp),
		.data			(data_out),
		.data_valid		(data_valid_out)
	);

endmodule

// File: tb/pid_lock_properties.sv
`timescale 1ns/1ps
`include "pid_lock_defines.svh"

module pid_lock_properties (
	input	logic					clk_in,
	input	logic					reset_in,
	input	logic					sample_valid_in,
	input	logic					update_en_in,
	input	logic					update_in,
	input	lock_data_pkg::out_t	output_max_in,
	input	lock_data_pkg::out_t	output_min_in,
	input	lock_data_pkg::out_t	data_out,
	input	logic					data_valid_out
);

	int unsigned			fail_count = 0;	// read by the testbench at the end
	logic [1:0]				busy_cnt;		// filter cycles left before FILT_IDLE
	logic					accepted;
	lock_data_pkg::out_t	max_q;			// bounds as held by the bank
	lock_data_pkg::out_t	min_q;

	assign accepted = sample_valid_in && (busy_cnt == 2'd0);

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			busy_cnt <= 2'd0;
		end else if (accepted) begin
			busy_cnt <= 2'd3;	// terms, sum, send
		end else if (busy_cnt != 2'd0) begin
			busy_cnt <= busy_cnt - 2'd1;
		end
	end

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			max_q <= `MAX_INIT;
			min_q <= `MIN_INIT;
		end else if (update_in && update_en_in) begin
			max_q <= output_max_in;	// same guard as the bank
			min_q <= output_min_in;
		end
	end

	////////////////////////////////////////////////////////////
	// output timing and range
	////////////////////////////////////////////////////////////

	single_pulse: assert property (@(posedge clk_in) disable iff (reset_in)
		data_valid_out |=> !data_valid_out)
		else begin
			$error("data_valid_out high two cycles in a row");
			fail_count++;
		end

	five_cycle_latency: assert property (@(posedge clk_in) disable iff (reset_in)
		accepted |-> ##5 data_valid_out)
		else begin
			$error("data_valid_out missing 5 cycles after an accepted sample");
			fail_count++;
		end

	// lower bound wins when the bounds cross
	output_in_bounds: assert property (@(posedge clk_in) disable iff (reset_in)
		data_valid_out |-> (data_out >= min_q) && ((data_out <= max_q) || (min_q > max_q)))
		else begin
			$error("data_out outside the output bounds");
			fail_count++;
		end

	quiet_after_reset: assert property (@(posedge clk_in)
		reset_in |=> !data_valid_out)
		else begin
			$error("data_valid_out high in the cycle after reset");
			fail_count++;
		end

endmodule

bind pid_lock_top pid_lock_properties props_i (
	.clk_in			(clk_in),
	.reset_in		(reset_in),
	.sample_valid_in	(sample_valid_in),
	.update_en_in	(update_en_in),
	.update_in		(update_in),
	.output_max_in	(output_max_in),
	.output_min_in	(output_min_in),
	.data_out		(data_out),
	.data_valid_out	(data_valid_out)
);

// File: tb/pid_lock_tb.sv
`timescale 1ns/1ps
`include "pid_lock_defines.svh"

module pid_lock_tb;

	localparam int TIMEOUT = 20;	// cycles to wait for data_valid_out

	logic	clk_in, reset_in, sample_valid_in, lock_en_in, update_en_in, update_in;
	logic	data_valid_out;
	lock_data_pkg::sample_t		sample_in, setpoint_in;
	lock_config_pkg::coef_t		kp_in, ki_in, kd_in;
	lock_data_pkg::out_t		output_max_in, output_min_in, output_init_in, data_out;
	lock_config_pkg::mult_t		multiplier_in;
	lock_config_pkg::div_t		divisor_in;

	longint	m_setpoint, m_kp, m_ki, m_kd;	// stored filter coefficients
	longint	m_max, m_min, m_init, m_mult, m_div;	// stored output stage values
	longint	m_integ, m_err_prev, m_prev;	// loop history
	int		errors;			// in the running test
	int		tests_run;
	int		tests_failed;

	pid_lock_top dut_i (.*);

	initial begin
		clk_in = 1'b0;
		forever #5 clk_in = ~clk_in;	// 10 ns period
	end

	////////////////////////////////////////////////////////////
	// reference model and helpers
	////////////////////////////////////////////////////////////

	function automatic longint predict_output(input longint smp);
		longint err;
		longint res;
		err = m_setpoint - smp;
		if (lock_en_in) begin
			m_integ = m_integ + m_ki * err;	// integral includes this error
			res = m_kp * err + m_integ + m_kd * (err - m_err_prev);
			m_err_prev = err;
			res = (res * m_mult) / m_div + m_prev;	// truncates toward zero
		end else begin
			res = m_init;	// unlocked output
		end
		if (res > m_max) begin
			res = m_max;
		end
		if (res < m_min) begin
			res = m_min;
		end
		m_prev = res;
		return res;
	endfunction

	function automatic longint rand_sample(input longint center, input int span);
		return center + longint'($urandom % (2 * span + 1)) - span;
	endfunction

	task automatic check_value(input string name, input longint expected, input longint actual);
		assert (expected == actual) else begin
			$display("CHECK FAILED %s expected %h got %h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic apply_config(input longint sp, input longint kp, input longint ki,
		input longint kd, input longint mx, input longint mn, input longint init,
		input longint mult, input longint dvs, input logic en);
		@(negedge clk_in);
		setpoint_in		= lock_data_pkg::sample_t'(sp);
		kp_in			= lock_config_pkg::coef_t'(kp);
		ki_in			= lock_config_pkg::coef_t'(ki);
		kd_in			= lock_config_pkg::coef_t'(kd);
		output_max_in	= lock_data_pkg::out_t'(mx);
		output_min_in	= lock_data_pkg::out_t'(mn);
		output_init_in	= lock_data_pkg::out_t'(init);
		multiplier_in	= lock_config_pkg::mult_t'(mult);
		divisor_in		= lock_config_pkg::div_t'(dvs);
		update_en_in	= en;
		update_in		= 1'b1;
		@(negedge clk_in);
		update_in		= 1'b0;
		update_en_in	= 1'b0;
		if (en) begin
			m_setpoint	= sp;
			m_kp		= kp;
			m_ki		= ki;
			m_kd		= kd;
			m_max		= mx;
			m_min		= mn;
			m_init		= init;
			m_mult		= mult;
			m_div		= (dvs == 0) ? 1 : dvs;	// zero divisor acts as one
			m_prev		= init;	// load pulse reloads the previous output
		end
		repeat (2) @(negedge clk_in);
	endtask

	task automatic set_lock(input logic en);
		@(negedge clk_in);
		lock_en_in = en;
		if (!en) begin
			m_integ		= 0;	// history cleared while unlocked
			m_err_prev	= 0;
		end
		@(negedge clk_in);
	endtask

	// intrude adds a second strobe 2 cycles after the first
	task automatic send_sample(input longint smp, input bit intrude, output longint got);
		longint	expected;
		int		cycles;
		int		extra;
		expected	= predict_output(smp);
		got			= 0;
		cycles		= 0;
		extra		= 0;
		@(negedge clk_in);
		sample_in		= lock_data_pkg::sample_t'(smp);
		sample_valid_in	= 1'b1;
		do begin
			@(negedge clk_in);
			cycles++;
			sample_valid_in = intrude && (cycles == 2);	// lands in FILT_SUM
			if (sample_valid_in) begin
				sample_in = ~sample_in;
			end
		end while (!data_valid_out && cycles < TIMEOUT);
		if (!data_valid_out) begin
			$display("timeout: no data_valid_out within %0d cycles of a sample", TIMEOUT);
			errors++;
		end else begin
			got = longint'(data_out);
			check_value("data_out", expected, got);
			check_value("output latency", 5, longint'(cycles));
		end
		for (int i = 0; i < (intrude ? 12 : 1); i++) begin
			@(negedge clk_in);	// writeback cycle or the window for a dropped sample
			if (data_valid_out) begin
				extra++;
			end
		end
		if (extra != 0) begin
			$display("a dropped sample still produced an output");
			errors++;
		end
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (errors == 0) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors);
		end
		errors = 0;
	endtask

	////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////

	initial begin
		longint			got;
		int unsigned	prop_fails;
		void'($urandom(32'h1f56_880c));
		reset_in		= 1'b1;
		sample_valid_in	= 1'b0;
		lock_en_in		= 1'b0;
		update_en_in	= 1'b0;
		update_in		= 1'b0;
		sample_in		= '0;
		setpoint_in		= '0;
		kp_in			= '0;
		ki_in			= '0;
		kd_in			= '0;
		output_max_in	= `MAX_INIT;
		output_min_in	= `MIN_INIT;
		output_init_in	= `OUT_INIT;
		multiplier_in	= `MLT_INIT;
		divisor_in		= `DVS_INIT;
		{m_setpoint, m_kp, m_ki, m_kd, m_integ, m_err_prev} = '0;
		m_max		= longint'($signed(`MAX_INIT));	// bank reset values
		m_min		= longint'($signed(`MIN_INIT));
		m_init		= longint'($signed(`OUT_INIT));
		m_mult		= longint'($signed(`MLT_INIT));
		m_div		= longint'($signed(`DVS_INIT));
		m_prev		= m_init;
		errors			= 0;
		tests_run		= 0;
		tests_failed	= 0;
		repeat (2) @(negedge clk_in);
		reset_in = 1'b0;

		for (int i = 0; i < 8; i++) begin
			@(negedge clk_in);
			check_value("data_valid_out", 0, longint'(data_valid_out));
		end
		send_sample(rand_sample(0, 30000), 1'b0, got);
		check_value("data_out", longint'($signed(`OUT_INIT)), got);
		finish_test("reset state");

		apply_config(0, 0, 0, 0, 16383, -16383, 291, 1, 1, 1'b1);
		for (int i = 0; i < 4; i++) begin
			send_sample(rand_sample(0, 30000), 1'b0, got);
		end
		finish_test("lock disabled");

		apply_config(0, 5, 0, 0, 16383, -16383, 0, 3, 7, 1'b1);
		set_lock(1'b1);
		for (int i = 0; i < 8; i++) begin
			send_sample(rand_sample(0, 500), 1'b0, got);
		end
		finish_test("proportional accumulation");

		apply_config(100, 3, 1, 2, 16383, -16383, 0, 1, 4, 1'b1);
		for (int i = 0; i < 10; i++) begin
			send_sample(rand_sample(100, 200), 1'b0, got);
		end
		set_lock(1'b0);
		send_sample(rand_sample(100, 200), 1'b0, got);
		set_lock(1'b1);	// integral restarts from zero
		for (int i = 0; i < 3; i++) begin
			send_sample(rand_sample(100, 200), 1'b0, got);
		end
		finish_test("full pid");

		apply_config(0, 100, 0, 0, 4096, -4096, 512, 1, 1, 1'b1);
		for (int i = 0; i < 2; i++) begin
			send_sample(-20000, 1'b0, got);
			check_value("data_out at max", 4096, got);
		end
		for (int i = 0; i < 2; i++) begin
			send_sample(20000, 1'b0, got);
			check_value("data_out at min", -4096, got);
		end
		finish_test("clamping");

		set_lock(1'b0);
		apply_config(50, 9, 9, 9, 100, -100, 1365, 5, 5, 1'b0);	// not armed
		send_sample(rand_sample(0, 1000), 1'b0, got);
		check_value("data_out after ignored update", 512, got);
		apply_config(0, 2, 0, 0, 16383, -16383, 0, 1, 0, 1'b1);
		set_lock(1'b1);
		for (int i = 0; i < 3; i++) begin
			send_sample(rand_sample(0, 1000), 1'b0, got);
		end
		send_sample(rand_sample(0, 1000), 1'b1, got);
		finish_test("update guards");

		prop_fails = dut_i.props_i.fail_count;
		$display("tests run %0d, failed %0d, assertion failures %0d",
			tests_run, tests_failed, prop_fails);
		if (tests_failed == 0 && prop_fails == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// File: pid_lock.f
+incdir+verilog
verilog/lock_data_pkg.sv
verilog/lock_config_pkg.sv
verilog/lock_ifs.sv
verilog/lock_config_bank.sv
verilog/pid_filter.sv
verilog/output_preprocessor.sv
verilog/pid_lock_top.sv
tb/pid_lock_properties.sv
tb/pid_lock_tb.sv

// File: Makefile
# Verilator build for the PID lock loop testbench

VERILATOR	?= verilator
TOP			?= pid_lock_tb
FILELIST	?= pid_lock.f
BUILD_DIR	?= obj_dir
VFLAGS		?= --binary --timing --assert -j 0
RUN_ARGS	?= +verilator+error+limit+1000
PASS_MSG	?= All tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# the status of the last grep decides pass or fail
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
